//--- filelist.f
+incdir+rtl
rtl/ooo_types_pkg.sv
rtl/ooo_bus_pkg.sv
rtl/latency_timer.sv
rtl/exec_unit.sv
rtl/register_map.sv
rtl/reorder_buffer.sv
rtl/dispatch_ctrl.sv
rtl/ooo_core_top.sv
test/tb_ooo_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the core and its testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    -f filelist.f --top-module tb_ooo_core -o tb_ooo_core

./obj_dir/tb_ooo_core | tee sim.log

if grep -qx "Simulation PASSED" sim.log; then
    exit 0
else
    echo "Test did not pass, see sim.log"
    exit 1
fi

//--- test/tb_ooo_core.sv
// Testbench for the out-of-order core. Drives an instruction table through the
// valid/ready port with random idle gaps, predicts every retirement and redirect
// with a reference model and checks them as they leave the core
`include "ooo_macros.svh"

module tb_ooo_core;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_INSTR = 33;
    localparam int CLK_HALF  = 4;
    localparam int RST_CYC   = 4;
    localparam int DRAIN_CYC = 20;
    localparam int WDOG_CYC  = 40 * NUM_INSTR;

    // One predicted event at the core outputs, either a retirement or a redirect
    typedef struct packed {
        logic                     is_redirect;
        ooo_types_pkg::reg_idx_t  rdest;
        ooo_types_pkg::data_t     data;
    } exp_event_t;

    logic                  clk = 1'b0;
    logic                  n_rst;
    logic                  instr_valid;
    ooo_bus_pkg::instr_t   instr;
    logic                  instr_ready;
    ooo_bus_pkg::retire_t  retire;
    logic                  redirect;
    ooo_types_pkg::data_t  redirect_addr;

    ooo_bus_pkg::instr_t   prog [NUM_INSTR];
    exp_event_t            exp_q [$];
    int                    checks = 0;
    int                    value_errors = 0;
    int                    other_errors = 0;
    int                    seed = 32'hdd77;

    ooo_core_top i_dut (
        .clk           (clk),
        .n_rst         (n_rst),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .instr_ready   (instr_ready),
        .retire        (retire),
        .redirect      (redirect),
        .redirect_addr (redirect_addr)
    );

    always #(CLK_HALF) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("ERROR: %s is 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_problem(input string what);
        other_errors++;
        $display("Problem at %0t: %s", $time, what);
    endtask

    function automatic void put_instr(input int idx, input ooo_types_pkg::rob_op_t op,
                                      input int rd, input int s0, input int s1,
                                      input logic [31:0] imm);
        prog[idx].op     = op;
        prog[idx].rdest  = ooo_types_pkg::reg_idx_t'(rd);
        prog[idx].src[0] = ooo_types_pkg::reg_idx_t'(s0);
        prog[idx].src[1] = ooo_types_pkg::reg_idx_t'(s1);
        prog[idx].imm    = imm;
    endfunction

    // Idle cycles before the next table entry is offered
    function automatic int next_gap();
        return $unsigned($random(seed)) % 3;
    endfunction

    // Branch targets are table indices, so a redirect restarts the table there
    task automatic load_program();
        // Plain load-immediates
        put_instr(0, ooo_types_pkg::op_li, 1, 0, 0, 32'h0000_0005);
        put_instr(1, ooo_types_pkg::op_li, 2, 0, 0, 32'h0000_0007);
        put_instr(2, ooo_types_pkg::op_li, 3, 0, 0, 32'h0000_0100);
        // Dependent ALU chain, each result feeds the next one
        put_instr(3, ooo_types_pkg::op_add, 4, 1, 2, '0);
        put_instr(4, ooo_types_pkg::op_sub, 5, 4, 1, '0);
        put_instr(5, ooo_types_pkg::op_xor, 6, 5, 3, '0);
        put_instr(6, ooo_types_pkg::op_add, 7, 6, 6, '0);
        // Multiply followed by independent loads and a consumer
        put_instr(7, ooo_types_pkg::op_mul, 8, 7, 2, '0);
        put_instr(8, ooo_types_pkg::op_li, 9, 0, 0, 32'h0000_0011);
        put_instr(9, ooo_types_pkg::op_li, 10, 0, 0, 32'h0000_0022);
        put_instr(10, ooo_types_pkg::op_add, 11, 8, 9, '0);
        // Long run of loads behind a second multiply
        put_instr(11, ooo_types_pkg::op_mul, 12, 11, 11, '0);
        for (int i = 0; i < 8; i++) begin
            put_instr(12 + i, ooo_types_pkg::op_li, 13 + (i % 3), 0, 0, 32'h0000_1000 + i);
        end
        // Taken branch over three entries that must never retire
        put_instr(20, ooo_types_pkg::op_beq, 0, 1, 1, 32'd24);
        put_instr(21, ooo_types_pkg::op_li, 1, 0, 0, 32'h0000_dead);
        put_instr(22, ooo_types_pkg::op_li, 2, 0, 0, 32'h0000_beef);
        put_instr(23, ooo_types_pkg::op_add, 3, 1, 1, '0);
        put_instr(24, ooo_types_pkg::op_add, 9, 1, 2, '0);
        // Branch that falls through
        put_instr(25, ooo_types_pkg::op_beq, 0, 1, 2, 32'd27);
        put_instr(26, ooo_types_pkg::op_sub, 10, 2, 1, '0);
        put_instr(27, ooo_types_pkg::op_xor, 11, 9, 10, '0);
        put_instr(28, ooo_types_pkg::op_mul, 0, 9, 10, '0);
        put_instr(29, ooo_types_pkg::op_li, 15, 0, 0, 32'h0000_5a5a);
        // Taken branch close to the end of the table
        put_instr(30, ooo_types_pkg::op_beq, 0, 15, 15, 32'd32);
        put_instr(31, ooo_types_pkg::op_li, 15, 0, 0, 32'h0000_0000);
        put_instr(32, ooo_types_pkg::op_add, 14, 15, 0, '0);
    endtask

    // The reference model walks the table in program order from zeroed registers
    task automatic build_expected();
        ooo_types_pkg::data_t  regs [`OOO_NUM_REGS];
        ooo_types_pkg::data_t  a;
        ooo_types_pkg::data_t  b;
        ooo_types_pkg::data_t  res;
        logic [63:0]           prod;
        exp_event_t            ev;
        int                    pc;
        for (int r = 0; r < `OOO_NUM_REGS; r++) begin
            regs[r] = '0;
        end
        pc = 0;
        while (pc < NUM_INSTR) begin
            a   = regs[prog[pc].src[0]];
            b   = regs[prog[pc].src[1]];
            res = '0;
            case (prog[pc].op)
                ooo_types_pkg::op_li:  res = prog[pc].imm;
                ooo_types_pkg::op_add: res = a + b;
                ooo_types_pkg::op_sub: res = a - b;
                ooo_types_pkg::op_xor: res = a ^ b;
                ooo_types_pkg::op_mul: begin
                    prod = {32'd0, a} * {32'd0, b};
                    res  = prod[31:0];
                end
                default: res = '0;
            endcase
            if (prog[pc].op == ooo_types_pkg::op_beq) begin
                // Only a taken branch is visible at the ports
                if (a == b) begin
                    ev = '{is_redirect: 1'b1, rdest: '0, data: prog[pc].imm};
                    exp_q.push_back(ev);
                    pc = int'(prog[pc].imm);
                end else begin
                    pc++;
                end
            end else begin
                regs[prog[pc].rdest] = res;
                ev = '{is_redirect: 1'b0, rdest: prog[pc].rdest, data: res};
                exp_q.push_back(ev);
                pc++;
            end
        end
    endtask

    task automatic compare_retire();
        exp_event_t ev;
        if (exp_q.size() == 0) begin
            report_problem("a retirement appeared with no event left to expect");
        end else begin
            ev = exp_q.pop_front();
            if (ev.is_redirect) begin
                report_problem("a retirement appeared where a redirect was expected");
            end else begin
                check_value("retire.rdest", 32'(retire.rdest), 32'(ev.rdest));
                check_value("retire.data", retire.data, ev.data);
            end
        end
    endtask

    task automatic compare_redirect();
        exp_event_t ev;
        if (exp_q.size() == 0) begin
            report_problem("a redirect appeared with no event left to expect");
        end else begin
            ev = exp_q.pop_front();
            if (!ev.is_redirect) begin
                report_problem("a redirect appeared where a retirement was expected");
            end else begin
                check_value("redirect_addr", redirect_addr, ev.data);
            end
        end
    endtask

    // The monitor samples mid-cycle where outputs are settled
    // When a retirement and a redirect share a cycle the retirement is the older one
    initial begin
        forever begin
            @(negedge clk);
            if (n_rst) begin
                if (retire.valid) begin
                    compare_retire();
                end
                if (redirect) begin
                    compare_redirect();
                end
            end
        end
    end

    initial begin
        repeat (WDOG_CYC) @(posedge clk);
        report_problem("watchdog expired before all expected events were seen");
        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int   idx;
        int   gap;
        logic accepted;
        n_rst       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        load_program();
        build_expected();

        repeat (RST_CYC) @(posedge clk);
        @(negedge clk);
        check_value("retire.valid", 32'(retire.valid), 32'd0);
        check_value("redirect", 32'(redirect), 32'd0);
        n_rst = 1'b1;

        idx      = 0;
        gap      = next_gap();
        accepted = 1'b0;
        // Keep running until the model's events are all seen
        // A late redirect may still send the driver back into the table
        while (idx < NUM_INSTR || accepted || exp_q.size() != 0) begin
            @(negedge clk);
            if (accepted) begin
                // Anything but a load-immediate keeps dispatch busy after acceptance
                if (prog[idx].op != ooo_types_pkg::op_li) begin
                    check_value("instr_ready", 32'(instr_ready), 32'd0);
                end
                idx++;
                accepted    = 1'b0;
                instr_valid = 1'b0;
                gap         = next_gap();
            end
            if (redirect) begin
                // No instruction is taken in the flush cycle
                check_value("instr_ready", 32'(instr_ready), 32'd0);
                // Everything younger than the branch is flushed, refetch from the target
                idx         = int'(redirect_addr);
                instr_valid = 1'b0;
                gap         = next_gap();
            end else if (idx < NUM_INSTR) begin
                if (gap > 0) begin
                    gap--;
                end else begin
                    instr_valid = 1'b1;
                    instr       = prog[idx];
                    // Ready only depends on core state, so it is stable here
                    accepted    = instr_ready;
                end
            end
        end
        instr_valid = 1'b0;

        // Extra cycles catch retirements that should not happen
        repeat (DRAIN_CYC) @(negedge clk);
        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- rtl/ooo_core_top.sv
// Top level of the out-of-order core around the re-order buffer
// Instruction input is valid/ready, retirement and redirect are valid-only outputs
module ooo_core_top (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  instr_valid,
    input  ooo_bus_pkg::instr_t   instr,
    output logic                  instr_ready,
    output ooo_bus_pkg::retire_t  retire,
    output logic                  redirect,
    output ooo_types_pkg::data_t  redirect_addr
);

    logic                         alloc_en;
    logic                         rob_full;
    logic                         tag_wr_en;
    logic                         issue_valid;
    logic                         exec_done;
    ooo_types_pkg::rob_tag_t      alloc_tag;
    ooo_types_pkg::rob_tag_t      retire_tag;
    ooo_types_pkg::reg_idx_t      tag_wr_reg;
    ooo_bus_pkg::operand_t [1:0]  lookup;
    ooo_bus_pkg::operand_t [1:0]  src;
    ooo_bus_pkg::cdb_t            cdb;
    ooo_bus_pkg::issue_t          issue;

    reorder_buffer i_rob (
        .clk           (clk),
        .n_rst         (n_rst),
        .alloc_en      (alloc_en),
        .instr         (instr),
        .cdb           (cdb),
        .lookup        (lookup),
        .alloc_tag     (alloc_tag),
        .full          (rob_full),
        .src           (src),
        .tag_wr_en     (tag_wr_en),
        .tag_wr_reg    (tag_wr_reg),
        .retire        (retire),
        .retire_tag    (retire_tag),
        .redirect      (redirect),
        .redirect_addr (redirect_addr)
    );

    // The redirect pulse doubles as the flush of every other block
    register_map i_regmap (
        .clk        (clk),
        .n_rst      (n_rst),
        .src_idx    (instr.src),
        .tag_wr_en  (tag_wr_en),
        .tag_wr_reg (tag_wr_reg),
        .tag_wr_tag (alloc_tag),
        .retire     (retire),
        .retire_tag (retire_tag),
        .flush      (redirect),
        .lookup     (lookup)
    );

    dispatch_ctrl i_dispatch (
        .clk         (clk),
        .n_rst       (n_rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rob_full    (rob_full),
        .alloc_tag   (alloc_tag),
        .src         (src),
        .cdb         (cdb),
        .exec_done   (exec_done),
        .flush       (redirect),
        .instr_ready (instr_ready),
        .alloc_en    (alloc_en),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    exec_unit i_exec (
        .clk         (clk),
        .n_rst       (n_rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .flush       (redirect),
        .cdb         (cdb),
        .exec_done   (exec_done)
    );

endmodule

//--- rtl/dispatch_ctrl.sv
// Dispatch FSM that takes one instruction at a time from the input port
// Holds its operands until both are ready, then issues it to the execution unit
module dispatch_ctrl (
    input  logic                          clk,
    input  logic                          n_rst,
    input  logic                          instr_valid,
    input  ooo_bus_pkg::instr_t           instr,
    input  logic                          rob_full,
    input  ooo_types_pkg::rob_tag_t       alloc_tag,
    input  ooo_bus_pkg::operand_t [1:0]   src,
    input  ooo_bus_pkg::cdb_t             cdb,
    input  logic                          exec_done,
    input  logic                          flush,
    output logic                          instr_ready,
    output logic                          alloc_en,
    output logic                          issue_valid,
    output ooo_bus_pkg::issue_t           issue
);

    ooo_types_pkg::disp_state_t  state;
    ooo_types_pkg::disp_state_t  state_nxt;
    logic                        issued;
    ooo_types_pkg::rob_op_t      op_q;
    ooo_types_pkg::rob_tag_t     tag_q;
    ooo_types_pkg::data_t        imm_q;
    ooo_bus_pkg::operand_t [1:0] opnd_q;
    ooo_bus_pkg::operand_t [1:0] opnd_nxt;

    assign instr_ready = (state == ooo_types_pkg::st_idle) && !rob_full && !flush;
    assign alloc_en    = instr_valid && instr_ready;

    // Pick up a missing operand when its producer broadcasts
    always_comb begin
        opnd_nxt = opnd_q;
        for (int i = 0; i < 2; i++) begin
            if (!opnd_q[i].rdy && cdb.en && (cdb.tag == opnd_q[i].tag)) begin
                opnd_nxt[i].rdy  = 1'b1;
                opnd_nxt[i].data = cdb.data;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ooo_types_pkg::st_idle: begin
                // Load-immediates complete in the ROB and never leave idle
                if (alloc_en && (instr.op != ooo_types_pkg::op_li)) begin
                    state_nxt = (src[0].rdy && src[1].rdy) ? ooo_types_pkg::st_issue
                                                           : ooo_types_pkg::st_wait;
                end
            end
            ooo_types_pkg::st_wait: begin
                if (opnd_nxt[0].rdy && opnd_nxt[1].rdy) begin
                    state_nxt = ooo_types_pkg::st_issue;
                end
            end
            ooo_types_pkg::st_issue: begin
                if (exec_done) begin
                    state_nxt = ooo_types_pkg::st_idle;
                end
            end
            default: state_nxt = ooo_types_pkg::st_idle;
        endcase
        if (flush) begin
            state_nxt = ooo_types_pkg::st_idle;
        end
    end

    // Stay in st_issue while executing, issued marks the pulse as sent
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state  <= ooo_types_pkg::st_idle;
            issued <= 1'b0;
        end else begin
            state  <= state_nxt;
            issued <= (state_nxt == ooo_types_pkg::st_issue) && (issued || issue_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            op_q   <= instr.op;
            tag_q  <= alloc_tag;
            imm_q  <= instr.imm;
            opnd_q <= src;
        end else begin
            opnd_q <= opnd_nxt;
        end
    end

    assign issue_valid    = (state == ooo_types_pkg::st_issue) && !issued;
    assign issue.op       = op_q;
    assign issue.tag      = tag_q;
    assign issue.src_data = {opnd_q[1].data, opnd_q[0].data};
    assign issue.imm      = imm_q;

endmodule

//--- rtl/reorder_buffer.sv
// Circular re-order buffer of the core
// Allocates at the tail, completes entries from the CDB and retires from the head in order
// Also resolves source operands for the instruction being dispatched
`include "ooo_macros.svh"

module reorder_buffer (
    input  logic                          clk,
    input  logic                          n_rst,
    input  logic                          alloc_en,
    input  ooo_bus_pkg::instr_t           instr,
    input  ooo_bus_pkg::cdb_t             cdb,
    input  ooo_bus_pkg::operand_t [1:0]   lookup,
    output ooo_types_pkg::rob_tag_t       alloc_tag,
    output logic                          full,
    output ooo_bus_pkg::operand_t [1:0]   src,
    output logic                          tag_wr_en,
    output ooo_types_pkg::reg_idx_t       tag_wr_reg,
    output ooo_bus_pkg::retire_t          retire,
    output ooo_types_pkg::rob_tag_t       retire_tag,
    output logic                          redirect,
    output ooo_types_pkg::data_t          redirect_addr
);

    localparam int TAG_W = $bits(ooo_types_pkg::rob_tag_t);

    typedef struct packed {
        logic                     rdy;
        logic                     branch;
        logic                     has_dest;
        ooo_types_pkg::reg_idx_t  rdest;
        ooo_types_pkg::data_t     data;
        ooo_types_pkg::data_t     target;
    } rob_entry_t;

    rob_entry_t               entries [`OOO_ROB_DEPTH];
    ooo_types_pkg::rob_ptr_t  head;
    ooo_types_pkg::rob_ptr_t  tail;
    ooo_types_pkg::rob_tag_t  head_idx;
    rob_entry_t               head_entry;
    logic                     empty;
    logic                     head_done;
    logic                     retire_go;
    logic                     ret_valid_q;
    ooo_types_pkg::reg_idx_t  ret_rdest_q;
    ooo_types_pkg::data_t     ret_data_q;
    ooo_types_pkg::rob_tag_t  ret_tag_q;

    assign head_idx  = head[TAG_W-1:0];
    assign alloc_tag = tail[TAG_W-1:0];
    assign empty     = (head == tail);
    // Same index with opposite wrap bits means every entry is in use
    assign full      = (head[TAG_W] != tail[TAG_W]) && (head_idx == alloc_tag);

    assign head_entry = entries[head_idx];
    assign head_done  = !empty && head_entry.rdy;
    // A taken branch never retires, it flushes the whole buffer instead
    assign retire_go  = head_done && !head_entry.branch;

    assign redirect      = head_done && head_entry.branch;
    assign redirect_addr = head_entry.target;

    // Branches own no destination, so they leave the register map alone
    assign tag_wr_en  = alloc_en && (instr.op != ooo_types_pkg::op_beq);
    assign tag_wr_reg = instr.rdest;

    // Operand priority is register map, then same-cycle CDB, then ROB entry
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (lookup[i].rdy) begin
                src[i] = lookup[i];
            end else if (cdb.en && (cdb.tag == lookup[i].tag)) begin
                src[i] = '{rdy: 1'b1, tag: cdb.tag, data: cdb.data};
            end else begin
                src[i] = '{rdy:  entries[lookup[i].tag].rdy,
                           tag:  lookup[i].tag,
                           data: entries[lookup[i].tag].data};
            end
        end
    end

    // Completion and allocation both land when they target different entries
    // Allocation comes last so it owns an entry that both would touch
    always_ff @(posedge clk) begin
        if (cdb.en) begin
            entries[cdb.tag].rdy    <= 1'b1;
            entries[cdb.tag].branch <= cdb.branch;
            entries[cdb.tag].data   <= cdb.data;
            entries[cdb.tag].target <= cdb.target;
        end
        if (alloc_en) begin
            // A load-immediate carries its result and is complete at once
            entries[alloc_tag] <= '{rdy:      (instr.op == ooo_types_pkg::op_li),
                                    branch:   1'b0,
                                    has_dest: (instr.op != ooo_types_pkg::op_beq),
                                    rdest:    instr.rdest,
                                    data:     instr.imm,
                                    target:   '0};
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            head        <= '0;
            tail        <= '0;
            ret_valid_q <= 1'b0;
        end else if (redirect) begin
            head        <= '0;
            tail        <= '0;
            ret_valid_q <= 1'b0;
        end else begin
            if (alloc_en) begin
                tail <= tail + 1'b1;
            end
            if (retire_go) begin
                head <= head + 1'b1;
            end
            // A branch that falls through retires without a register write
            ret_valid_q <= retire_go && head_entry.has_dest;
        end
    end

    always_ff @(posedge clk) begin
        if (retire_go) begin
            ret_rdest_q <= head_entry.rdest;
            ret_data_q  <= head_entry.data;
            ret_tag_q   <= head_idx;
        end
    end

    assign retire     = '{valid: ret_valid_q, rdest: ret_rdest_q, data: ret_data_q};
    assign retire_tag = ret_tag_q;

endmodule

//--- rtl/register_map.sv
// Architectural register file with a busy bit and producer tag per register
// Looked up at dispatch, tagged at allocation and written at retirement
`include "ooo_macros.svh"

module register_map (
    input  logic                              clk,
    input  logic                              n_rst,
    input  ooo_types_pkg::reg_idx_t [1:0]     src_idx,
    input  logic                              tag_wr_en,
    input  ooo_types_pkg::reg_idx_t           tag_wr_reg,
    input  ooo_types_pkg::rob_tag_t           tag_wr_tag,
    input  ooo_bus_pkg::retire_t              retire,
    input  ooo_types_pkg::rob_tag_t           retire_tag,
    input  logic                              flush,
    output ooo_bus_pkg::operand_t [1:0]       lookup
);

    ooo_types_pkg::data_t     regs [`OOO_NUM_REGS];
    ooo_types_pkg::rob_tag_t  tags [`OOO_NUM_REGS];
    logic [`OOO_NUM_REGS-1:0] busy;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int r = 0; r < `OOO_NUM_REGS; r++) begin
                regs[r] <= '0;
                tags[r] <= '0;
            end
            busy <= '0;
        end else begin
            if (retire.valid) begin
                regs[retire.rdest] <= retire.data;
                // A younger producer may have retagged the register meanwhile
                if (tags[retire.rdest] == retire_tag) begin
                    busy[retire.rdest] <= 1'b0;
                end
            end
            if (flush) begin
                busy <= '0;
            end
            // New producer wins over a retirement to the same register
            if (tag_wr_en) begin
                busy[tag_wr_reg] <= 1'b1;
                tags[tag_wr_reg] <= tag_wr_tag;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            lookup[i].rdy  = !busy[src_idx[i]];
            lookup[i].tag  = tags[src_idx[i]];
            lookup[i].data = regs[src_idx[i]];
        end
    end

endmodule

//--- rtl/exec_unit.sv
// Single execution unit for ALU, multiply and branch compare
// Holds one operation until its latency runs out, then drives the CDB
`include "ooo_macros.svh"

module exec_unit (
    input  logic                 clk,
    input  logic                 n_rst,
    input  logic                 issue_valid,
    input  ooo_bus_pkg::issue_t  issue,
    input  logic                 flush,
    output ooo_bus_pkg::cdb_t    cdb,
    output logic                 exec_done
);

    ooo_bus_pkg::issue_t   op_q;
    ooo_types_pkg::data_t  a;
    ooo_types_pkg::data_t  b;
    ooo_types_pkg::data_t  result;
    logic [2:0]            cycles;
    logic                  start;
    logic                  busy;
    logic                  done;

    // A new operation is taken only once the previous one has finished
    assign start  = issue_valid && !busy;
    assign cycles = (issue.op == ooo_types_pkg::op_mul) ? 3'(`OOO_MUL_LAT) : 3'd1;

    latency_timer i_timer (
        .clk    (clk),
        .n_rst  (n_rst),
        .load   (start),
        .cycles (cycles),
        .abort  (flush),
        .busy   (busy),
        .done   (done)
    );

    always_ff @(posedge clk) begin
        if (start) begin
            op_q <= issue;
        end
    end

    assign a = op_q.src_data[0];
    assign b = op_q.src_data[1];

    always_comb begin
        case (op_q.op)
            ooo_types_pkg::op_add: result = a + b;
            ooo_types_pkg::op_sub: result = a - b;
            ooo_types_pkg::op_xor: result = a ^ b;
            // Only the low word of the product is kept
            ooo_types_pkg::op_mul: result = a * b;
            default:               result = '0;
        endcase
    end

    assign cdb.en     = done;
    assign cdb.tag    = op_q.tag;
    assign cdb.data   = result;
    assign cdb.branch = (op_q.op == ooo_types_pkg::op_beq) && (a == b);
    assign cdb.target = op_q.imm;
    assign exec_done  = done;

endmodule

//--- rtl/latency_timer.sv
// Loadable down-counter timing an operation inside the execution unit
// done is high in the last cycle before the count reaches zero
module latency_timer (
    input  logic       clk,
    input  logic       n_rst,
    input  logic       load,
    input  logic [2:0] cycles,
    input  logic       abort,
    output logic       busy,
    output logic       done
);

    logic [2:0] count;

    assign busy = (count != 3'd0);
    assign done = (count == 3'd1);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            count <= '0;
        end else if (abort) begin
            count <= '0;
        end else if (load) begin
            count <= cycles;
        end else if (busy) begin
            count <= count - 3'd1;
        end
    end

endmodule

//--- rtl/ooo_bus_pkg.sv
// Bundles that travel between the core blocks and out of the top level
// Built only from the scalar types of ooo_types_pkg
package ooo_bus_pkg;

    // One instruction at the core input
    typedef struct packed {
        ooo_types_pkg::rob_op_t        op;
        ooo_types_pkg::reg_idx_t       rdest;
        ooo_types_pkg::reg_idx_t [1:0] src;
        ooo_types_pkg::data_t          imm;
    } instr_t;

    // A source operand, either ready with data or waiting on a tag
    typedef struct packed {
        logic                     rdy;
        ooo_types_pkg::rob_tag_t  tag;
        ooo_types_pkg::data_t     data;
    } operand_t;

    // Common data bus, one broadcast per cycle at most
    typedef struct packed {
        logic                     en;
        ooo_types_pkg::rob_tag_t  tag;
        ooo_types_pkg::data_t     data;
        logic                     branch;
        ooo_types_pkg::data_t     target;
    } cdb_t;

    // In-order register write from the ROB head
    typedef struct packed {
        logic                     valid;
        ooo_types_pkg::reg_idx_t  rdest;
        ooo_types_pkg::data_t     data;
    } retire_t;

    // Operation handed to the execution unit
    typedef struct packed {
        ooo_types_pkg::rob_op_t        op;
        ooo_types_pkg::rob_tag_t       tag;
        ooo_types_pkg::data_t [1:0]    src_data;
        ooo_types_pkg::data_t          imm;
    } issue_t;

endpackage

//--- rtl/ooo_types_pkg.sv
// Scalar types of the core: meaningful widths and the enumerations
// Compiled before ooo_bus_pkg and every RTL module
`include "ooo_macros.svh"

package ooo_types_pkg;

    typedef logic [`OOO_DATA_W-1:0]                data_t;
    typedef logic [$clog2(`OOO_NUM_REGS)-1:0]      reg_idx_t;
    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0]     rob_tag_t;
    // One extra bit on top of the index tells full from empty
    typedef logic [$clog2(`OOO_ROB_DEPTH):0]       rob_ptr_t;

    typedef enum logic [2:0] {
        op_li,
        op_add,
        op_sub,
        op_xor,
        op_mul,
        op_beq
    } rob_op_t;

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_issue
    } disp_state_t;

endpackage

//--- rtl/ooo_macros.svh
// Size constants shared by the core packages and RTL modules
// Include this header wherever a width or depth is needed
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// Data word width, also used for branch targets
`define OOO_DATA_W    32
// Architectural register count
`define OOO_NUM_REGS  16
// Re-order buffer entries, must be a power of two
`define OOO_ROB_DEPTH 8
// Cycles a multiply stays in the execution unit
`define OOO_MUL_LAT   4

`endif
